// File: rtl/i2c_pkg.sv
// I2C master peripheral shared definitions
// Register map indices, transfer engine phases and common widths
`default_nettype none

package i2c_pkg;

    // Bus data width of every word register
    localparam int REGISTER_WIDTH = 32;

    // One I2C data byte on the wire
    localparam int BYTE_WIDTH = 8;

    // Timebase ticks that make up one SCL bit period
    // SCL is low for the first half of them and high for the second half
    localparam int TICKS_PER_BIT = 4;

    // Word register selected by bus address bits 3:2
    typedef enum logic [1:0] {
        reg_control      = 2'd0,
        reg_timebase_div = 2'd1,
        reg_transfer     = 2'd2,
        reg_status       = 2'd3
    } reg_index_t;

    // Phases of the bit-level transfer sequencer
    typedef enum logic [2:0] {
        idle         = 3'd0,
        start_cond   = 3'd1,
        send_byte    = 3'd2,
        ack_in       = 3'd3,
        restart_cond = 3'd4,
        recv_byte    = 3'd5,
        ack_out      = 3'd6,
        stop_cond    = 3'd7
    } engine_state_t;

endpackage

`default_nettype wire

// File: rtl/i2c_control_unit.sv
// I2C peripheral control unit
// Holds the control, divider and transfer registers plus the status latch,
// serves bus reads and turns a transfer register write into a start pulse
`timescale 1ns/100ps
`default_nettype none

module i2c_control_unit import i2c_pkg::*; #(
    parameter logic [REGISTER_WIDTH-1:0] INITIAL_PRESCALE = 1
) (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      bus_write,
    input  wire logic                      bus_read,
    input  wire logic [3:0]                bus_address,
    input  wire logic [REGISTER_WIDTH-1:0] bus_write_data,
    output logic      [REGISTER_WIDTH-1:0] bus_read_data,
    input  wire logic                      done,
    input  wire logic [BYTE_WIDTH-1:0]     read_data,
    input  wire logic                      ack_error,
    output logic                           direction,
    output logic                           timebase_enable,
    output logic      [REGISTER_WIDTH-1:0] prescale,
    output logic      [6:0]                target_address,
    output logic      [BYTE_WIDTH-1:0]     register_address,
    output logic      [BYTE_WIDTH-1:0]     write_data,
    output logic                           start
);

    typedef enum logic [1:0] {
        idle_state             = 2'd0,
        comm_start_state       = 2'd1,
        comm_in_progress_state = 2'd2
    } cu_state_t;

    cu_state_t state;

    reg_index_t                index;
    logic                      trigger;
    logic                      busy;
    logic [BYTE_WIDTH-1:0]     status_byte;
    logic                      status_ack_error;
    logic [REGISTER_WIDTH-1:0] read_word;

    // Only bits 3:2 pick the word, the byte lane bits are don't care
    assign index = reg_index_t'(bus_address[3:2]);

    // A transfer register write arms a new transfer
    assign trigger = bus_write && (index == reg_transfer);

    assign busy = (state != idle_state);

    // Writable registers, status is read only so its writes fall through
    always_ff @(posedge clock) begin
        if (!reset) begin
            direction        <= 1'b0;
            timebase_enable  <= 1'b0;
            prescale         <= INITIAL_PRESCALE;
            register_address <= '0;
            target_address   <= '0;
            write_data       <= '0;
        end else if (bus_write) begin
            case (index)
                reg_control: begin
                    direction       <= bus_write_data[0];
                    timebase_enable <= bus_write_data[1];
                end
                reg_timebase_div: prescale <= bus_write_data;
                reg_transfer: begin
                    // Fields update even mid transfer, the engine keeps its own copy
                    register_address <= bus_write_data[7:0];
                    target_address   <= bus_write_data[14:8];
                    write_data       <= bus_write_data[23:16];
                end
                default: ;
            endcase
        end
    end

    // Result of the last transfer, captured when the engine reports done
    always_ff @(posedge clock) begin
        if (!reset) begin
            status_byte      <= '0;
            status_ack_error <= 1'b0;
        end else if (done) begin
            status_byte      <= read_data;
            status_ack_error <= ack_error;
        end
    end

    always_comb begin
        case (index)
            reg_control:      read_word = {{(REGISTER_WIDTH-2){1'b0}}, timebase_enable, direction};
            reg_timebase_div: read_word = prescale;
            reg_transfer: begin
                // Bit 15 and the top byte are reserved and read as zero
                read_word = {{(REGISTER_WIDTH-24){1'b0}}, write_data, 1'b0,
                             target_address, register_address};
            end
            default: begin
                read_word = {{(REGISTER_WIDTH-BYTE_WIDTH-2){1'b0}}, status_ack_error,
                             busy, status_byte};
            end
        endcase
    end

    // Read data appears the cycle after the strobe and holds until the next read
    always_ff @(posedge clock) begin
        if (bus_read) begin
            bus_read_data <= read_word;
        end
    end

    // Start pulse lasts exactly the comm_start cycle
    // Triggers that arrive while a transfer runs are dropped
    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle_state;
            start <= 1'b0;
        end else begin
            case (state)
                idle_state: begin
                    if (trigger) begin
                        state <= comm_start_state;
                        start <= 1'b1;
                    end
                end
                comm_start_state: begin
                    start <= 1'b0;
                    state <= comm_in_progress_state;
                end
                comm_in_progress_state: begin
                    if (done) begin
                        state <= idle_state;
                    end
                end
                default: begin
                    start <= 1'b0;
                    state <= idle_state;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/i2c_timebase.sv
// I2C timebase generator
// Divides the system clock into a tick stream, one tick per quarter SCL bit
`timescale 1ns/100ps
`default_nettype none

module i2c_timebase (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic        enable,
    input  wire logic [31:0] prescale,
    output logic             tick
);

    logic [31:0] counter;
    logic        wrap;

    // The counter spans prescale+1 clock cycles per tick
    assign wrap = (counter == prescale);

    always_ff @(posedge clock) begin
        if (!reset) begin
            counter <= '0;
            tick    <= 1'b0;
        end else if (!enable) begin
            // Held at zero so that a fresh enable waits a full period
            counter <= '0;
            tick    <= 1'b0;
        end else if (wrap) begin
            counter <= '0;
            tick    <= 1'b1;
        end else begin
            counter <= counter + 32'd1;
            tick    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/i2c_transfer_engine.sv
// I2C transfer engine
// Bit-level sequencer for single-byte register writes and reads,
// stepping one quarter bit per timebase tick and checking every acknowledge
`timescale 1ns/100ps
`default_nettype none

module i2c_transfer_engine import i2c_pkg::*; (
    input  wire logic                  clock,
    input  wire logic                  reset,
    input  wire logic                  tick,
    input  wire logic                  start,
    input  wire logic                  direction,
    input  wire logic [6:0]            target_address,
    input  wire logic [BYTE_WIDTH-1:0] register_address,
    input  wire logic [BYTE_WIDTH-1:0] write_data,
    output logic                       scl,
    output logic                       sda_out,
    output logic                       sda_enable,
    input  wire logic                  sda_in,
    output logic                       done,
    output logic      [BYTE_WIDTH-1:0] read_data,
    output logic                       ack_error
);

    localparam int PHASE_WIDTH = $clog2(TICKS_PER_BIT);

    // SCL falls on the first phase and rises halfway through the bit
    localparam logic [PHASE_WIDTH-1:0] DRIVE_PHASE = '0;
    localparam logic [PHASE_WIDTH-1:0] RISE_PHASE = PHASE_WIDTH'(TICKS_PER_BIT / 2);
    localparam logic [PHASE_WIDTH-1:0] LAST_PHASE = PHASE_WIDTH'(TICKS_PER_BIT - 1);

    // Byte slots: 0 address+W, 1 register, 2 data or address+R
    localparam logic [1:0] LAST_BYTE = 2'd2;

    engine_state_t state;

    logic [PHASE_WIDTH-1:0] phase;
    logic [2:0]             bit_count;
    logic [1:0]             byte_count;
    logic [1:0]             next_index;
    logic [BYTE_WIDTH-1:0]  shift;
    logic [BYTE_WIDTH-1:0]  next_byte;
    logic                   drive_low;
    logic                   step_end;

    logic                  direction_q;
    logic [6:0]            target_q;
    logic [BYTE_WIDTH-1:0] register_q;
    logic [BYTE_WIDTH-1:0] data_q;

    // Open drain, the pin is only ever pulled low
    assign sda_out = 1'b0;

    // Tick that closes the current bit period
    assign step_end = tick && (state != idle) && (phase == LAST_PHASE);

    // Next byte to shift out once the current one is acknowledged
    always_comb begin
        next_index = byte_count + 2'd1;
        case (next_index)
            2'd1:    next_byte = register_q;
            default: next_byte = direction_q ? {target_q, 1'b1} : data_q;
        endcase
    end

    // Level that SDA takes while SCL is low in the current state
    always_comb begin
        case (state)
            send_byte: drive_low = ~shift[BYTE_WIDTH-1];
            stop_cond: drive_low = 1'b1;
            default:   drive_low = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= idle;
            phase      <= '0;
            bit_count  <= '0;
            byte_count <= '0;
            scl        <= 1'b1;
            sda_enable <= 1'b0;
            done       <= 1'b0;
            ack_error  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == idle) begin
                phase <= '0;
                if (start) begin
                    state      <= start_cond;
                    bit_count  <= '0;
                    byte_count <= '0;
                    ack_error  <= 1'b0;
                end
            end else if (tick) begin
                phase <= (phase == LAST_PHASE) ? '0 : phase + 1'b1;

                // START keeps SCL high, every other bit gets a full clock pulse
                if (state != start_cond) begin
                    if (phase == DRIVE_PHASE) begin
                        scl        <= 1'b0;
                        sda_enable <= drive_low;
                    end
                    if (phase == RISE_PHASE) begin
                        scl <= 1'b1;
                    end
                end

                case (state)
                    start_cond: begin
                        // SDA falls while SCL stays high
                        if (phase == RISE_PHASE) sda_enable <= 1'b1;
                        if (phase == LAST_PHASE) state <= send_byte;
                    end
                    send_byte: begin
                        if (phase == LAST_PHASE) begin
                            bit_count <= bit_count + 3'd1;
                            if (bit_count == 3'd7) state <= ack_in;
                        end
                    end
                    ack_in: begin
                        if (phase == LAST_PHASE) begin
                            if (sda_in) begin
                                // No acknowledge, abandon the transfer
                                ack_error <= 1'b1;
                                state     <= stop_cond;
                            end else if (byte_count == LAST_BYTE) begin
                                state <= direction_q ? recv_byte : stop_cond;
                            end else begin
                                byte_count <= next_index;
                                if (direction_q && byte_count == 2'd1) begin
                                    state <= restart_cond;
                                end else begin
                                    state <= send_byte;
                                end
                            end
                        end
                    end
                    restart_cond: begin
                        // Repeated START, SDA falls late in the high half
                        if (phase == LAST_PHASE) begin
                            sda_enable <= 1'b1;
                            state      <= send_byte;
                        end
                    end
                    recv_byte: begin
                        if (phase == LAST_PHASE) begin
                            bit_count <= bit_count + 3'd1;
                            if (bit_count == 3'd7) state <= ack_out;
                        end
                    end
                    ack_out: begin
                        // SDA stays released, which answers the byte with NACK
                        if (phase == LAST_PHASE) state <= stop_cond;
                    end
                    stop_cond: begin
                        // SDA rises while SCL is high
                        if (phase == LAST_PHASE) begin
                            sda_enable <= 1'b0;
                            done       <= 1'b1;
                            state      <= idle;
                        end
                    end
                    default: state <= idle;
                endcase
            end
        end
    end

    // Transfer fields and the data shifter
    // Fields are copied at start so that register writes cannot disturb the bus
    always_ff @(posedge clock) begin
        if (state == idle && start) begin
            direction_q <= direction;
            target_q    <= target_address;
            register_q  <= register_address;
            data_q      <= write_data;
            shift       <= {target_address, 1'b0};
            read_data   <= '0;
        end else if (step_end) begin
            case (state)
                send_byte: shift <= {shift[BYTE_WIDTH-2:0], 1'b0};
                recv_byte: begin
                    shift <= {shift[BYTE_WIDTH-2:0], sda_in};
                    if (bit_count == 3'd7) read_data <= {shift[BYTE_WIDTH-2:0], sda_in};
                end
                ack_in: begin
                    if (!sda_in && byte_count != LAST_BYTE) shift <= next_byte;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/i2c_peripheral.sv
// I2C master peripheral top level
// Control unit and timebase side by side, both feeding the transfer engine
`timescale 1ns/100ps
`default_nettype none

module i2c_peripheral import i2c_pkg::*; #(
    parameter logic [REGISTER_WIDTH-1:0] INITIAL_PRESCALE = 1
) (
    input  wire logic                      clock,
    input  wire logic                      reset,
    input  wire logic                      bus_write,
    input  wire logic                      bus_read,
    input  wire logic [3:0]                bus_address,
    input  wire logic [REGISTER_WIDTH-1:0] bus_write_data,
    output wire logic [REGISTER_WIDTH-1:0] bus_read_data,
    output wire logic                      scl,
    output wire logic                      sda_out,
    output wire logic                      sda_enable,
    input  wire logic                      sda_in
);

    // Control unit to timebase
    logic                      timebase_enable;
    logic [REGISTER_WIDTH-1:0] prescale;

    // Control unit to engine
    logic                  start;
    logic                  direction;
    logic [6:0]            target_address;
    logic [BYTE_WIDTH-1:0] register_address;
    logic [BYTE_WIDTH-1:0] write_data;

    // Engine back to the control unit
    logic                  done;
    logic [BYTE_WIDTH-1:0] read_data;
    logic                  ack_error;

    logic tick;

    i2c_control_unit #(
        .INITIAL_PRESCALE(INITIAL_PRESCALE)
    ) control_unit (
        .clock(clock),
        .reset(reset),
        .bus_write(bus_write),
        .bus_read(bus_read),
        .bus_address(bus_address),
        .bus_write_data(bus_write_data),
        .bus_read_data(bus_read_data),
        .done(done),
        .read_data(read_data),
        .ack_error(ack_error),
        .direction(direction),
        .timebase_enable(timebase_enable),
        .prescale(prescale),
        .target_address(target_address),
        .register_address(register_address),
        .write_data(write_data),
        .start(start)
    );

    i2c_timebase timebase (
        .clock(clock),
        .reset(reset),
        .enable(timebase_enable),
        .prescale(prescale),
        .tick(tick)
    );

    i2c_transfer_engine engine (
        .clock(clock),
        .reset(reset),
        .tick(tick),
        .start(start),
        .direction(direction),
        .target_address(target_address),
        .register_address(register_address),
        .write_data(write_data),
        .scl(scl),
        .sda_out(sda_out),
        .sda_enable(sda_enable),
        .sda_in(sda_in),
        .done(done),
        .read_data(read_data),
        .ack_error(ack_error)
    );

endmodule

`default_nettype wire

// File: verif/i2c_target_model.sv
// Behavioral I2C target for the peripheral testbench
// Acknowledges one fixed address and serves a 16-byte register array,
// pulling SDA low through a wired-and with the master
`timescale 1ns/100ps
`default_nettype none

module i2c_target_model #(
    parameter logic [6:0] ADDRESS = 7'h2A
) (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic scl,
    input  wire logic sda,
    output logic      pull_low
);

    typedef enum logic [1:0] {
        receive_mode,
        ack_mode,
        send_mode,
        wait_mode
    } target_mode_t;

    target_mode_t mode;

    logic [7:0] memory [0:15];
    logic [7:0] shift;
    logic [7:0] send_data;
    logic [3:0] bit_count;
    logic [3:0] pointer;
    logic [1:0] byte_count;
    logic       reading;
    logic       last_scl;
    logic       last_sda;
    logic       start_seen;
    logic       stop_seen;
    logic       scl_rise;
    logic       scl_fall;

    // Bus conditions, judged from the line levels one clock apart
    assign start_seen = last_scl && scl && last_sda && !sda;
    assign stop_seen  = last_scl && scl && !last_sda && sda;
    assign scl_rise   = !last_scl && scl;
    assign scl_fall   = last_scl && !scl;

    always @(posedge clock) begin
        if (!reset) begin
            mode       <= wait_mode;
            pull_low   <= 1'b0;
            bit_count  <= '0;
            byte_count <= '0;
            pointer    <= '0;
            reading    <= 1'b0;
            last_scl   <= 1'b1;
            last_sda   <= 1'b1;
            // Power-up contents mix every address bit into the byte
            for (int i = 0; i < 16; i++) begin
                memory[i] <= 8'(i * 29) ^ 8'h5a;
            end
        end else begin
            last_scl <= scl;
            last_sda <= sda;
            if (start_seen) begin
                // START or repeated START, an address byte follows
                mode       <= receive_mode;
                bit_count  <= '0;
                byte_count <= '0;
                pull_low   <= 1'b0;
            end else if (stop_seen) begin
                mode     <= wait_mode;
                pull_low <= 1'b0;
            end else if (scl_rise && mode == receive_mode) begin
                shift     <= {shift[6:0], sda};
                bit_count <= bit_count + 4'd1;
            end else if (scl_fall) begin
                case (mode)
                    receive_mode: begin
                        if (bit_count == 4'd8) begin
                            if (byte_count == 2'd0 && shift[7:1] != ADDRESS) begin
                                // Someone else's address, stay off the bus until STOP
                                mode <= wait_mode;
                            end else begin
                                pull_low <= 1'b1;
                                mode     <= ack_mode;
                                if (byte_count == 2'd0) reading <= shift[0];
                                if (byte_count == 2'd1) pointer <= shift[3:0];
                                if (byte_count == 2'd2) memory[pointer] <= shift;
                            end
                        end
                    end
                    ack_mode: begin
                        if (reading) begin
                            // First data bit goes out as the acknowledge ends
                            send_data <= {memory[pointer][6:0], 1'b0};
                            pull_low  <= ~memory[pointer][7];
                            bit_count <= 4'd1;
                            mode      <= send_mode;
                        end else begin
                            pull_low   <= 1'b0;
                            bit_count  <= '0;
                            byte_count <= byte_count + 2'd1;
                            mode       <= receive_mode;
                        end
                    end
                    send_mode: begin
                        if (bit_count == 4'd8) begin
                            // Master answers the byte itself
                            pull_low <= 1'b0;
                            mode     <= wait_mode;
                        end else begin
                            pull_low  <= ~send_data[7];
                            send_data <= {send_data[6:0], 1'b0};
                            bit_count <= bit_count + 4'd1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/i2c_peripheral_tb.sv
// Testbench for the I2C master peripheral
// Replays register and transfer tests from a data file against a target model
`timescale 1ns/100ps
`default_nettype none

module i2c_peripheral_tb import i2c_pkg::*; ();

    localparam int CLOCK_PERIOD = 40;
    localparam int MAX_TESTS = 64;
    localparam logic [REGISTER_WIDTH-1:0] INITIAL_PRESCALE = 1;

    logic                      clock;
    logic                      reset;
    logic                      bus_write;
    logic                      bus_read;
    logic [3:0]                bus_address;
    logic [REGISTER_WIDTH-1:0] bus_write_data;
    wire logic [REGISTER_WIDTH-1:0] bus_read_data;
    wire logic scl;
    wire logic sda_out;
    wire logic sda_enable;
    wire logic sda_line;
    wire logic target_pull_low;

    logic [3:0]                test_op       [0:MAX_TESTS-1];
    logic [1:0]                test_index    [0:MAX_TESTS-1];
    logic [REGISTER_WIDTH-1:0] test_value    [0:MAX_TESTS-1];
    logic [REGISTER_WIDTH-1:0] test_expected [0:MAX_TESTS-1];

    int     test_count;
    int     current_test;
    int     error_count;
    int     cycle_count = 0;
    int     cycle_limit = 0;
    integer seed;

    // Open-drain SDA with a pull-up that either side can pull low
    assign sda_line = !(sda_enable && !sda_out) && !target_pull_low;

    i2c_peripheral #(
        .INITIAL_PRESCALE(INITIAL_PRESCALE)
    ) UUT (
        .clock(clock),
        .reset(reset),
        .bus_write(bus_write),
        .bus_read(bus_read),
        .bus_address(bus_address),
        .bus_write_data(bus_write_data),
        .bus_read_data(bus_read_data),
        .scl(scl),
        .sda_out(sda_out),
        .sda_enable(sda_enable),
        .sda_in(sda_line)
    );

    i2c_target_model #(
        .ADDRESS(7'h2A)
    ) target (
        .clock(clock),
        .reset(reset),
        .scl(scl),
        .sda(sda_line),
        .pull_low(target_pull_low)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Watchdog that is armed once the test file has set the limit
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run timed out after %0d clock cycles in test %0d",
                     cycle_count, current_test);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        assert (actual === expected) else begin
            error_count++;
            $display("Fail %0t: test %0d %s is %h, expected %h",
                     $time, current_test, what, actual, expected);
        end
    endtask

    // Address lane bits are random so only the word index may select the register
    task automatic write_register(input reg_index_t index, input logic [31:0] value);
        logic [1:0]  lane;
        logic [31:0] reserved;
        lane     = 2'($random(seed));
        reserved = $random(seed) & 32'hff00_8000;
        @(negedge clock);
        bus_write      = 1'b1;
        bus_address    = {index, lane};
        bus_write_data = (index == reg_transfer) ? (value | reserved) : value;
        @(negedge clock);
        bus_write = 1'b0;
    endtask

    task automatic read_register(input reg_index_t index, output logic [31:0] value);
        logic [1:0] lane;
        lane = 2'($random(seed));
        @(negedge clock);
        bus_read    = 1'b1;
        bus_address = {index, lane};
        @(negedge clock);
        bus_read = 1'b0;
        value    = bus_read_data;
    endtask

    // Polls status until busy clears and returns the final status word
    task automatic wait_idle(output logic [31:0] status);
        read_register(reg_status, status);
        while (status[8] !== 1'b0) begin
            read_register(reg_status, status);
        end
    endtask

    // Period of SCL from two rising edges inside one transfer
    task automatic measure_scl_period(input logic [31:0] transfer_word,
                                      input logic [31:0] prescale);
        time         first_rise;
        time         second_rise;
        logic [31:0] expected_period;
        logic [31:0] status;
        expected_period = TICKS_PER_BIT * (prescale + 1) * CLOCK_PERIOD;
        write_register(reg_transfer, transfer_word);
        @(posedge scl);
        first_rise = $time;
        @(posedge scl);
        second_rise = $time;
        check_value(32'(second_rise - first_rise), expected_period, "SCL period in ns");
        wait_idle(status);
    endtask

    // A transfer with no ticks must keep SCL high and stay busy
    task automatic hold_stalled(input logic [31:0] span, input logic [31:0] expected);
        logic [31:0] status;
        int          cycle;
        read_register(reg_status, status);
        check_value(status, expected, "status before the stall");
        for (cycle = 0; cycle < span; cycle++) begin
            @(negedge clock);
            assert (scl === 1'b1) else begin
                error_count++;
                $display("Fail %0t: test %0d SCL moved while the timebase was off",
                         $time, current_test);
            end
        end
        read_register(reg_status, status);
        check_value(status, expected, "status after the stall");
    endtask

    task automatic run_test(input int number);
        reg_index_t  index;
        logic [31:0] value;
        logic [31:0] expected;
        logic [31:0] result;
        index    = reg_index_t'(test_index[number]);
        value    = test_value[number];
        expected = test_expected[number];
        case (test_op[number])
            4'd0: write_register(index, value);
            4'd1: begin
                read_register(index, result);
                check_value(result, expected, "register");
            end
            4'd2: begin
                write_register(reg_transfer, value);
                wait_idle(result);
                check_value(result, expected, "transfer status");
            end
            4'd3: measure_scl_period(value, expected);
            4'd4: hold_stalled(value, expected);
            4'd5: begin
                wait_idle(result);
                check_value(result, expected, "transfer status");
            end
            default: begin
                error_count++;
                $display("Test %0d has an unknown operation code %0d", number, test_op[number]);
            end
        endcase
    endtask

    // Reads every test line and sizes the watchdog from the transfer count
    task automatic load_tests();
        integer      file;
        integer      fields;
        integer      character;
        logic [31:0] op_field;
        logic [31:0] index_field;
        logic [31:0] value_field;
        logic [31:0] expected_field;
        logic [31:0] largest_prescale;
        int          transfer_lines;
        largest_prescale = INITIAL_PRESCALE;
        transfer_lines   = 0;
        test_count       = 0;
        file = $fopen("verif/i2c_tests.txt", "r");
        if (file == 0) begin
            $display("Could not open the test file verif/i2c_tests.txt");
            $display("** FAIL **");
            $finish;
        end else begin
            while (!$feof(file)) begin
                fields = $fscanf(file, "%h %h %h %h\n", op_field, index_field,
                                 value_field, expected_field);
                if (fields == 4) begin
                    if (test_count < MAX_TESTS) begin
                        test_op[test_count]       = op_field[3:0];
                        test_index[test_count]    = index_field[1:0];
                        test_value[test_count]    = value_field;
                        test_expected[test_count] = expected_field;
                        if (op_field == 2 || op_field == 3 || op_field == 5) transfer_lines++;
                        if (op_field == 0 && index_field == reg_timebase_div &&
                            value_field > largest_prescale) largest_prescale = value_field;
                        if (op_field == 3 && expected_field > largest_prescale) begin
                            largest_prescale = expected_field;
                        end
                        test_count++;
                    end
                end else begin
                    // Lines that do not hold four hex fields are comments and are skipped
                    character = $fgetc(file);
                    while (character != 10 && character != -1) begin
                        character = $fgetc(file);
                    end
                end
            end
            $fclose(file);
            cycle_limit = 2 * transfer_lines * 39 * TICKS_PER_BIT * (int'(largest_prescale) + 1);
        end
    endtask

    initial begin
        reset          = 1'b0;
        bus_write      = 1'b0;
        bus_read       = 1'b0;
        bus_address    = '0;
        bus_write_data = '0;
        seed           = 32'h3e8da1c0;
        error_count    = 0;
        current_test   = 0;
        load_tests();
        repeat (16) @(negedge clock);
        reset = 1'b1;
        for (current_test = 0; current_test < test_count; current_test++) begin
            run_test(current_test);
        end
        $display("Tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0 && test_count > 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/i2c_tests.txt
# Columns: op index value expected, all hex; index 0 control 1 divider 2 transfer 3 status
# Ops: 0 write, 1 read check, 2 transfer, 3 SCL period (expected=prescale), 4 stall, 5 wait done
1 0 00000000 00000000
1 1 00000000 00000001
1 2 00000000 00000000
1 3 00000000 00000000
0 1 00000003 00000000
1 1 00000000 00000003
0 0 00000001 00000000
1 0 00000000 00000001
0 3 ffffffff 00000000
1 3 00000000 00000000
0 0 00000000 00000000
0 2 00a52a05 00000000
1 2 00000000 00a52a05
4 3 000000c8 00000100
0 0 00000002 00000000
5 3 00000000 00000000
0 0 00000003 00000000
2 2 00002a05 000000a5
0 0 00000000 00000000
0 1 00000001 00000000
0 0 00000002 00000000
2 2 003c2a0b 00000000
0 0 00000003 00000000
2 2 00002a0b 0000003c
0 0 00000002 00000000
2 2 00ff3305 00000200
0 0 00000003 00000000
2 2 00003305 00000200
2 2 00002a05 000000a5
0 0 00000000 00000000
0 1 00000003 00000000
0 0 00000002 00000000
3 2 00112a01 00000003
0 0 00000000 00000000
0 1 00000001 00000000
0 0 00000002 00000000
3 2 00222a02 00000001
0 0 00000003 00000000
2 2 00002a01 00000011
2 2 00002a02 00000022
1 3 00000000 00000022

// File: i2c_peripheral.f
rtl/i2c_pkg.sv
rtl/i2c_control_unit.sv
rtl/i2c_timebase.sv
rtl/i2c_transfer_engine.sv
rtl/i2c_peripheral.sv
verif/i2c_target_model.sv
verif/i2c_peripheral_tb.sv

// File: Bender.yml
package:
  name: i2c_peripheral

sources:
  - rtl/i2c_pkg.sv
  - rtl/i2c_control_unit.sv
  - rtl/i2c_timebase.sv
  - rtl/i2c_transfer_engine.sv
  - rtl/i2c_peripheral.sv
  - target: any(test, simulation)
    files:
      - verif/i2c_target_model.sv
      - verif/i2c_peripheral_tb.sv
